// File: sd_cmd_phy.f
source/sd_cmd_pkg.sv
source/sd_phy_state_pkg.sv
source/sd_cmd_bit_if.sv
source/sd_crc7.sv
source/sd_cmd_shifter.sv
source/sd_cmd_fsm.sv
source/sd_cmd_phy.sv
verification/tb_clock_gen.sv
verification/sd_cmd_phy_assert.sv
verification/tb_sd_cmd_phy.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SD command PHY testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sd_cmd_phy \
  -f sd_cmd_phy.f \
  -o Vtb_sd_cmd_phy

./obj_dir/Vtb_sd_cmd_phy 2>&1 | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi

// File: verification/tb_sd_cmd_phy.sv
`default_nettype none

module tb_sd_cmd_phy;

  import sd_cmd_pkg::*;

  localparam int DRIVE_DELAY = 10;
  localparam int WAIT_LIMIT  = 200;
  localparam int FRAME_W     = CMD_W + CRC_W + 1;

  logic       clk;
  logic       rst;
  logic       i_cmd_en;
  cmd_t       i_cmd;
  bit_count_t i_rsp_len;
  logic       i_sd_cmd;
  rsp_t       o_rsp;
  logic       o_rsp_done;
  logic       o_crc_err;
  logic       o_sd_cmd;
  logic       o_sd_cmd_dir;
  int         seed;

  tb_clock_gen #(.PERIOD(100)) u_clock (.o_clk(clk));

  sd_cmd_phy DUT (
    .i_sd_clk     (clk),
    .rst          (rst),
    .i_cmd_en     (i_cmd_en),
    .i_cmd        (i_cmd),
    .i_rsp_len    (i_rsp_len),
    .o_rsp        (o_rsp),
    .o_rsp_done   (o_rsp_done),
    .o_crc_err    (o_crc_err),
    .o_sd_cmd     (o_sd_cmd),
    .o_sd_cmd_dir (o_sd_cmd_dir),
    .i_sd_cmd     (i_sd_cmd)
  );

  // x^7 + x^3 + 1, MSB first from a zero state
  function automatic crc7_t ref_crc7(input logic [RSP_W:0] data, input int nbits);
    crc7_t crc;
    logic  fb;
    crc = '0;
    for (int i = nbits - 1; i >= 0; i--) begin
      fb  = crc[6] ^ data[i];
      crc = {crc[5:0], 1'b0};
      if (fb) begin
        crc = crc ^ 7'h09;
      end
    end
    return crc;
  endfunction

  // SD format: start bit 0, transmission bit 1
  function automatic cmd_t random_cmd();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return {2'b01, r[CMD_W-3:0]};
  endfunction

  task automatic step();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic fail_run();
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [RSP_W-1:0] expected,
                             input logic [RSP_W-1:0] actual);
    assert (actual === expected) else begin
      $display("Fail %s expected 0x%h actual 0x%h", name, expected, actual);
      fail_run();
    end
  endtask

  // Card side: frame starts at the first low bit while the host drives
  task automatic capture_frame(input cmd_t cmd);
    logic [FRAME_W-1:0] frame;
    logic [RSP_W:0]     data;
    int                 cnt;
    data = '0;
    data[CMD_W-1:0] = cmd;
    cnt = 0;
    while (!(o_sd_cmd_dir && !o_sd_cmd)) begin
      if (cnt == WAIT_LIMIT) begin
        $display("Timeout: the command frame never started on o_sd_cmd");
        fail_run();
      end
      cnt++;
      step();
    end
    for (int i = FRAME_W - 1; i >= 0; i--) begin
      check_value("o_sd_cmd_dir", 1, o_sd_cmd_dir);
      frame[i] = o_sd_cmd;
      step();
    end
    check_value("frame", {cmd, ref_crc7(data, CMD_W), 1'b1}, frame);
    check_value("o_sd_cmd_dir", 0, o_sd_cmd_dir);
  endtask

  task automatic send_response(input rsp_t payload, input int len, input int delay,
                               input bit flip);
    logic [RSP_W:0] data;
    crc7_t          crc;
    int             idx;
    data = '0;
    data[RSP_W-1:0] = payload;
    // Start bit sits above the payload and is zero
    crc = ref_crc7(data, len + 1);
    if (flip) begin
      idx      = $unsigned($random(seed)) % CRC_W;
      crc[idx] = ~crc[idx];
    end
    repeat (TURNAROUND_CYCLES + delay) step();
    i_sd_cmd = 1'b0;
    step();
    for (int i = len - 1; i >= 0; i--) begin
      i_sd_cmd = payload[i];
      step();
    end
    for (int i = CRC_W - 1; i >= 0; i--) begin
      i_sd_cmd = crc[i];
      step();
    end
    i_sd_cmd = 1'b1;
  endtask

  task automatic wait_done();
    int cnt;
    cnt = 0;
    while (!o_rsp_done) begin
      if (cnt == WAIT_LIMIT) begin
        $display("Timeout: o_rsp_done never rose after the response");
        fail_run();
      end
      cnt++;
      step();
    end
  endtask

  // One edge to be seen, one more for the pad registers
  task automatic drop_and_check();
    i_cmd_en = 1'b0;
    step();
    step();
    check_value("o_rsp_done", 0, o_rsp_done);
    check_value("o_sd_cmd_dir", 1, o_sd_cmd_dir);
    check_value("o_sd_cmd", 1, o_sd_cmd);
    check_value("o_crc_err", 0, o_crc_err);
  endtask

  task automatic run_command(input int len, input int delay, input bit flip);
    cmd_t cmd;
    rsp_t payload;
    rsp_t mask;
    cmd     = random_cmd();
    payload = {$random(seed), $random(seed), $random(seed), $random(seed)};
    mask    = (rsp_t'(1) << len) - 1;
    payload = payload & mask;
    i_cmd     = cmd;
    i_rsp_len = bit_count_t'(len);
    i_cmd_en  = 1'b1;
    capture_frame(cmd);
    send_response(payload, len, delay, flip);
    wait_done();
    check_value("o_sd_cmd_dir", 1, o_sd_cmd_dir);
    check_value("o_crc_err", flip, o_crc_err);
    check_value("o_rsp", payload, o_rsp);
    drop_and_check();
  endtask

  initial begin
    int delay;
    seed      = 66;
    rst       = 1'b1;
    i_cmd_en  = 1'b0;
    i_cmd     = '0;
    i_rsp_len = '0;
    i_sd_cmd  = 1'b1;
    repeat (5) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    step();
    check_value("o_rsp_done", 0, o_rsp_done);
    check_value("o_crc_err", 0, o_crc_err);
    check_value("o_sd_cmd_dir", 1, o_sd_cmd_dir);
    check_value("o_sd_cmd", 1, o_sd_cmd);
    check_value("o_rsp", 0, o_rsp);

    // Random frames with short responses
    for (int n = 0; n < 3; n++) begin
      run_command(39, 0, 1'b0);
    end

    // Long response after a random card delay
    delay = $unsigned($random(seed)) % 8;
    run_command(127, delay, 1'b0);
    check_value("o_rsp[127]", 0, o_rsp[RSP_W-1]);

    // Corrupted remote CRC
    run_command(39, 1, 1'b1);

    // Abort in the middle of the frame
    i_cmd     = random_cmd();
    i_rsp_len = bit_count_t'(39);
    i_cmd_en  = 1'b1;
    repeat (20) step();
    drop_and_check();

    // Abort while waiting for a card that never answers
    i_cmd    = random_cmd();
    i_cmd_en = 1'b1;
    capture_frame(i_cmd);
    repeat (6) step();
    check_value("o_sd_cmd_dir", 0, o_sd_cmd_dir);
    drop_and_check();

    run_command(39, 0, 1'b0);

    if (DUT.u_assert.assert_errors == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Bound protocol assertions reported errors");
      fail_run();
    end
  end

endmodule

`default_nettype wire

// File: verification/sd_cmd_phy_assert.sv
`default_nettype none

module sd_cmd_phy_assert (
  input logic i_sd_clk,
  input logic rst,
  input logic i_cmd_en,
  input logic o_sd_cmd,
  input logic o_sd_cmd_dir,
  input logic o_rsp_done
);

  import sd_cmd_pkg::*;

  // Consecutive cycles with the line released
  int unsigned low_run;
  int unsigned assert_errors;

  initial begin
    assert_errors = 0;
  end

  always_ff @(posedge i_sd_clk) begin
    if (rst || o_sd_cmd_dir) begin
      low_run <= 0;
    end else begin
      low_run <= low_run + 1;
    end
  end

  // Released pad keeps its output register idle
  released_pad_high: assert property (@(posedge i_sd_clk) disable iff (rst)
    !o_sd_cmd_dir |-> o_sd_cmd)
    else begin
      $error("o_sd_cmd low while the line is released");
      assert_errors = assert_errors + 1;
    end

  done_owns_line: assert property (@(posedge i_sd_clk) disable iff (rst)
    o_rsp_done |-> o_sd_cmd_dir)
    else begin
      $error("o_rsp_done high while the card owns the line");
      assert_errors = assert_errors + 1;
    end

  abort_clears_done: assert property (@(posedge i_sd_clk) disable iff (rst)
    !i_cmd_en |=> !o_rsp_done)
    else begin
      $error("o_rsp_done high after i_cmd_en low");
      assert_errors = assert_errors + 1;
    end

  turnaround_length: assert property (@(posedge i_sd_clk) disable iff (rst)
    $rose(o_sd_cmd_dir) |-> (low_run >= TURNAROUND_CYCLES))
    else begin
      $error("o_sd_cmd_dir low for fewer cycles than the turnaround");
      assert_errors = assert_errors + 1;
    end

endmodule

bind sd_cmd_phy sd_cmd_phy_assert u_assert (
  .i_sd_clk     (i_sd_clk),
  .rst          (rst),
  .i_cmd_en     (i_cmd_en),
  .o_sd_cmd     (o_sd_cmd),
  .o_sd_cmd_dir (o_sd_cmd_dir),
  .o_rsp_done   (o_rsp_done)
);

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 100
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  // Free running, half period high and half low
  always begin
    #(PERIOD / 2) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

// File: source/sd_cmd_phy.sv
`default_nettype none

module sd_cmd_phy (
  input  logic                    i_sd_clk,
  input  logic                    rst,

  // Host side
  input  logic                    i_cmd_en,
  input  sd_cmd_pkg::cmd_t        i_cmd,
  input  sd_cmd_pkg::bit_count_t  i_rsp_len,
  output sd_cmd_pkg::rsp_t        o_rsp,
  output logic                    o_rsp_done,
  output logic                    o_crc_err,

  // CMD pad, dir high while the host drives
  output logic                    o_sd_cmd,
  output logic                    o_sd_cmd_dir,
  input  logic                    i_sd_cmd
);

  sd_cmd_bit_if cmd_bits ();

  // Sequencer, counts bits and issues strobes
  sd_cmd_fsm u_fsm (
    .i_sd_clk   (i_sd_clk),
    .rst        (rst),
    .i_cmd_en   (i_cmd_en),
    .i_rsp_len  (i_rsp_len),
    .i_sd_cmd   (i_sd_cmd),
    .bits       (cmd_bits.ctrl),
    .o_rsp_done (o_rsp_done)
  );

  // Shift registers, CRC and pad registers
  sd_cmd_shifter u_shifter (
    .i_sd_clk     (i_sd_clk),
    .rst          (rst),
    .i_cmd        (i_cmd),
    .i_sd_cmd     (i_sd_cmd),
    .bits         (cmd_bits.datapath),
    .o_sd_cmd     (o_sd_cmd),
    .o_sd_cmd_dir (o_sd_cmd_dir),
    .o_rsp        (o_rsp),
    .o_crc_err    (o_crc_err)
  );

endmodule

`default_nettype wire

// File: source/sd_cmd_fsm.sv
`default_nettype none

module sd_cmd_fsm (
  input  logic                    i_sd_clk,
  input  logic                    rst,
  input  logic                    i_cmd_en,
  input  sd_cmd_pkg::bit_count_t  i_rsp_len,
  input  logic                    i_sd_cmd,
  sd_cmd_bit_if.ctrl              bits,
  output logic                    o_rsp_done
);

  import sd_cmd_pkg::*;
  import sd_phy_state_pkg::*;

  localparam bit_count_t CMD_LAST = bit_count_t'(CMD_W - 1);
  localparam bit_count_t CRC_LAST = bit_count_t'(CRC_W - 1);
  localparam bit_count_t CRC_ALL  = bit_count_t'(CRC_W);
  localparam bit_count_t TURN_END = bit_count_t'(TURNAROUND_CYCLES);

  cmd_state_t state;
  // Strobes issued so far in the current state
  bit_count_t bit_cnt;

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      state             <= IDLE;
      bit_cnt           <= '0;
      bits.load         <= 1'b0;
      bits.tx_cmd       <= 1'b0;
      bits.tx_crc       <= 1'b0;
      bits.tx_end       <= 1'b0;
      bits.release_line <= 1'b0;
      bits.rx_rsp       <= 1'b0;
      bits.rx_crc       <= 1'b0;
      bits.check        <= 1'b0;
      o_rsp_done        <= 1'b0;
    end else begin
      // Strobes are single cycle unless a state asks again
      bits.load         <= 1'b0;
      bits.tx_cmd       <= 1'b0;
      bits.tx_crc       <= 1'b0;
      bits.tx_end       <= 1'b0;
      bits.release_line <= 1'b0;
      bits.rx_rsp       <= 1'b0;
      bits.rx_crc       <= 1'b0;
      bits.check        <= 1'b0;
      o_rsp_done        <= 1'b0;

      case (state)
        IDLE: begin
          if (i_cmd_en) begin
            bits.load <= 1'b1;
            bit_cnt   <= '0;
            state     <= SEND_CMD;
          end
        end
        SEND_CMD: begin
          bits.tx_cmd <= 1'b1;
          bit_cnt     <= bit_cnt + 1'b1;
          if (bit_cnt == CMD_LAST) begin
            bit_cnt <= '0;
            state   <= SEND_CRC;
          end
        end
        SEND_CRC: begin
          bits.tx_crc <= 1'b1;
          bit_cnt     <= bit_cnt + 1'b1;
          if (bit_cnt == CRC_LAST) begin
            state <= SEND_END;
          end
        end
        SEND_END: begin
          bits.tx_end <= 1'b1;
          bit_cnt     <= '0;
          state       <= TURNAROUND;
        end
        TURNAROUND: begin
          // Line stays released from here until the check
          bits.release_line <= 1'b1;
          if (bit_cnt == TURN_END) begin
            state <= WAIT_START;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        WAIT_START: begin
          bits.release_line <= 1'b1;
          // First low level is the card's start bit
          if (!i_sd_cmd) begin
            bit_cnt <= bit_count_t'(1);
            if (i_rsp_len == '0) begin
              bits.rx_crc <= 1'b1;
              state       <= READ_CRC;
            end else begin
              bits.rx_rsp <= 1'b1;
              state       <= READ_RSP;
            end
          end
        end
        READ_RSP: begin
          bits.release_line <= 1'b1;
          if (bit_cnt == i_rsp_len) begin
            bits.rx_crc <= 1'b1;
            bit_cnt     <= bit_count_t'(1);
            state       <= READ_CRC;
          end else begin
            bits.rx_rsp <= 1'b1;
            bit_cnt     <= bit_cnt + 1'b1;
          end
        end
        READ_CRC: begin
          if (bit_cnt == CRC_ALL) begin
            // Compare and take the line back on the same edge
            bits.check <= 1'b1;
            state      <= CHECK_CRC;
          end else begin
            bits.release_line <= 1'b1;
            bits.rx_crc       <= 1'b1;
            bit_cnt           <= bit_cnt + 1'b1;
          end
        end
        CHECK_CRC: begin
          state <= DONE;
        end
        DONE: begin
          o_rsp_done <= 1'b1;
        end
        default: begin
          state <= IDLE;
        end
      endcase

      // Host abort overrides whatever the frame was doing
      if (!i_cmd_en) begin
        state             <= IDLE;
        bits.load         <= 1'b0;
        bits.tx_cmd       <= 1'b0;
        bits.tx_crc       <= 1'b0;
        // End strobe on the way out also clears the error flag
        bits.tx_end       <= (state != IDLE);
        bits.release_line <= 1'b0;
        bits.rx_rsp       <= 1'b0;
        bits.rx_crc       <= 1'b0;
        bits.check        <= 1'b0;
        o_rsp_done        <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/sd_cmd_shifter.sv
`default_nettype none

module sd_cmd_shifter (
  input  logic               i_sd_clk,
  input  logic               rst,
  input  sd_cmd_pkg::cmd_t   i_cmd,
  input  logic               i_sd_cmd,
  sd_cmd_bit_if.datapath     bits,
  output logic               o_sd_cmd,
  output logic               o_sd_cmd_dir,
  output sd_cmd_pkg::rsp_t   o_rsp,
  output logic               o_crc_err
);

  import sd_cmd_pkg::*;

  cmd_t  cmd_sr;
  crc7_t rmt_crc;
  crc7_t local_crc;
  logic  crc_clear;
  logic  crc_en;
  logic  crc_bit;

  // Fresh CRC per command, and again once the frame has gone out
  assign crc_clear = bits.load | bits.tx_end;
  assign crc_en    = bits.tx_cmd | bits.tx_crc | bits.rx_rsp;

  // While sending the CRC the register is fed its own MSB, so it drains to zero
  always_comb begin
    if (bits.tx_cmd) begin
      crc_bit = cmd_sr[CMD_W-1];
    end else if (bits.tx_crc) begin
      crc_bit = local_crc[CRC_W-1];
    end else begin
      crc_bit = i_sd_cmd;
    end
  end

  sd_crc7 u_crc7 (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clear  (crc_clear),
    .i_en     (crc_en),
    .i_bit    (crc_bit),
    .o_crc    (local_crc)
  );

  // Command word and remote CRC
  always_ff @(posedge i_sd_clk) begin
    if (bits.load) begin
      cmd_sr <= i_cmd;
    end else if (bits.tx_cmd) begin
      cmd_sr <= {cmd_sr[CMD_W-2:0], 1'b0};
    end
    if (bits.rx_crc) begin
      rmt_crc <= {rmt_crc[CRC_W-2:0], i_sd_cmd};
    end
  end

  // Pad registers, response and error flag
  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      o_sd_cmd     <= 1'b1;
      o_sd_cmd_dir <= 1'b1;
      o_rsp        <= '0;
      o_crc_err    <= 1'b0;
    end else begin
      o_sd_cmd_dir <= ~bits.release_line;
      // Idle high, end bit included
      if (bits.tx_cmd || bits.tx_crc) begin
        o_sd_cmd <= crc_bit;
      end else begin
        o_sd_cmd <= 1'b1;
      end

      if (bits.load) begin
        o_rsp <= '0;
      end else if (bits.rx_rsp) begin
        o_rsp <= {o_rsp[RSP_W-2:0], i_sd_cmd};
      end

      if (bits.load || bits.tx_end) begin
        o_crc_err <= 1'b0;
      end else if (bits.check) begin
        o_crc_err <= (rmt_crc != local_crc);
      end
    end
  end

endmodule

`default_nettype wire

// File: source/sd_crc7.sv
`default_nettype none

module sd_crc7 (
  input  logic               i_sd_clk,
  input  logic               rst,
  input  logic               i_clear,
  input  logic               i_en,
  input  logic               i_bit,
  output sd_cmd_pkg::crc7_t  o_crc
);

  import sd_cmd_pkg::*;

  logic feedback;

  // Top bit of the register meets the incoming bit
  assign feedback = o_crc[CRC_W-1] ^ i_bit;

  always_ff @(posedge i_sd_clk) begin
    if (rst || i_clear) begin
      o_crc <= '0;
    end else if (i_en) begin
      // Feeding back o_crc[6] itself just shifts the remainder out
      if (feedback) begin
        o_crc <= {o_crc[CRC_W-2:0], 1'b0} ^ CRC7_POLY;
      end else begin
        o_crc <= {o_crc[CRC_W-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// File: source/sd_cmd_bit_if.sv
`default_nettype none

// Per-bit commands from the sequencer to the CMD line datapath
interface sd_cmd_bit_if;

  logic load;
  logic tx_cmd;
  logic tx_crc;
  logic tx_end;
  logic release_line;
  logic rx_rsp;
  logic rx_crc;
  logic check;

  modport ctrl (
    output load,
    output tx_cmd,
    output tx_crc,
    output tx_end,
    output release_line,
    output rx_rsp,
    output rx_crc,
    output check
  );

  modport datapath (
    input load,
    input tx_cmd,
    input tx_crc,
    input tx_end,
    input release_line,
    input rx_rsp,
    input rx_crc,
    input check
  );

endinterface

`default_nettype wire

// File: source/sd_phy_state_pkg.sv
`default_nettype none

package sd_phy_state_pkg;

  // Command sequencer states, in frame order
  typedef enum logic [3:0] {
    IDLE,
    // Host owns the line
    SEND_CMD,
    SEND_CRC,
    SEND_END,
    // Line handed to the card
    TURNAROUND,
    WAIT_START,
    READ_RSP,
    READ_CRC,
    // Back to the host
    CHECK_CRC,
    DONE
  } cmd_state_t;

endpackage

`default_nettype wire

// File: source/sd_cmd_pkg.sv
`default_nettype none

package sd_cmd_pkg;

  // Command frame as it goes out on the CMD line
  localparam int unsigned CMD_W = 40;

  // Widest response payload the host keeps
  localparam int unsigned RSP_W = 128;

  // CRC7 over command and response bits
  localparam int unsigned CRC_W = 7;

  // Taps of x^7 + x^3 + 1, the x^7 term is implied
  localparam logic [CRC_W-1:0] CRC7_POLY = 7'h09;

  // Released-line cycles before the start bit is watched for
  localparam int unsigned TURNAROUND_CYCLES = 2;

  // Bit counter and response length share one width
  localparam int unsigned COUNT_W = 8;

  typedef logic [CMD_W-1:0] cmd_t;

  typedef logic [RSP_W-1:0] rsp_t;

  typedef logic [CRC_W-1:0] crc7_t;

  typedef logic [COUNT_W-1:0] bit_count_t;

endpackage

`default_nettype wire
